// File: hdl/isa_pkg.sv
`default_nettype none

package isa_pkg;

  // Data and instruction word
  typedef logic [31:0] word_t;

  // Architectural register index
  typedef logic [4:0] reg_idx_t;

  // Major opcodes handled by this slice
  typedef enum logic [6:0] {
    OP     = 7'b0110011,
    OP_IMM = 7'b0010011,
    LUI    = 7'b0110111
  } opcode_e;

  // funct3 encodings for OP and OP-IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 encodings, ALT selects SUB and SRA/SRAI
  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000;
  localparam int         ALT_BIT = 30;

  // Field positions in the instruction word
  localparam int OPCODE_LSB = 0;
  localparam int RD_LSB     = 7;
  localparam int FUNCT3_LSB = 12;
  localparam int RS1_LSB    = 15;
  localparam int RS2_LSB    = 20;
  localparam int FUNCT7_LSB = 25;
  localparam int IMM_I_LSB  = 20;
  localparam int IMM_U_LSB  = 12;

endpackage

`default_nettype wire

// File: hdl/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  // Operations performed by the execute stage
  typedef enum logic [3:0] {
    ADD,
    SUB,
    SLL,
    SLT,
    SLTU,
    XOR,
    SRL,
    SRA,
    OR,
    AND,
    // Second operand straight through, used by LUI
    PASS_B
  } alu_op_e;

  // Operand source at decode
  typedef enum logic {
    REGFILE = 1'b0,
    EXEC    = 1'b1
  } fwd_sel_e;

endpackage

`default_nettype wire

// File: hdl/instr_queue.sv
`default_nettype none
`timescale 1ns/1ps

module instr_queue #(
  parameter int IN_DEPTH = 4
) (
  input  wire             clk,
  input  wire             rst_n,
  input  wire             push,
  input  isa_pkg::word_t  push_data,
  input  wire             pop,
  output isa_pkg::word_t  head,
  output logic            empty
);

  localparam int PTR_W = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CNT_W = $clog2(IN_DEPTH + 1);

  isa_pkg::word_t   mem [IN_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;

  assign head  = mem[rd_ptr];
  assign empty = (count == '0);

  // Storage, written at the tail
  always_ff @(posedge clk)
  begin
    if (push)
      mem[wr_ptr] <= push_data;
  end

  // Pointers wrap explicitly so any depth works
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (push)
        wr_ptr <= (wr_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count <= count + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // Source only sends against credit, so a full queue never sees a push
  push_not_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> (count < CNT_W'(IN_DEPTH)));

endmodule

`default_nettype wire

// File: hdl/instr_decoder.sv
`default_nettype none
`timescale 1ns/1ps

module instr_decoder (
  input  isa_pkg::word_t     instr,
  output isa_pkg::reg_idx_t  rs1,
  output isa_pkg::reg_idx_t  rs2,
  output logic               rs1_used,
  output logic               rs2_used,
  output isa_pkg::reg_idx_t  rd,
  output isa_pkg::word_t     imm,
  output pipe_pkg::alu_op_e  alu_op,
  output logic               alu_src_imm,
  output logic               reg_write,
  output logic               illegal
);

  isa_pkg::opcode_e  opcode;
  logic [2:0]        funct3;
  logic [6:0]        funct7;
  logic              alt;
  logic              legal;
  pipe_pkg::alu_op_e f3_op;

  assign opcode = isa_pkg::opcode_e'(instr[isa_pkg::OPCODE_LSB +: 7]);
  assign funct3 = instr[isa_pkg::FUNCT3_LSB +: 3];
  assign funct7 = instr[isa_pkg::FUNCT7_LSB +: 7];
  assign alt    = instr[isa_pkg::ALT_BIT];
  assign rd     = instr[isa_pkg::RD_LSB +: 5];
  assign rs1    = instr[isa_pkg::RS1_LSB +: 5];
  assign rs2    = instr[isa_pkg::RS2_LSB +: 5];

  // Base operation from funct3, only the right shift looks at the alt bit here
  always_comb
  begin
    case (funct3)
      isa_pkg::F3_SLL:     f3_op = pipe_pkg::SLL;
      isa_pkg::F3_SLT:     f3_op = pipe_pkg::SLT;
      isa_pkg::F3_SLTU:    f3_op = pipe_pkg::SLTU;
      isa_pkg::F3_XOR:     f3_op = pipe_pkg::XOR;
      isa_pkg::F3_SRL_SRA: f3_op = alt ? pipe_pkg::SRA : pipe_pkg::SRL;
      isa_pkg::F3_OR:      f3_op = pipe_pkg::OR;
      isa_pkg::F3_AND:     f3_op = pipe_pkg::AND;
      default:             f3_op = pipe_pkg::ADD;
    endcase
  end

  always_comb
  begin
    // Defaults describe an illegal instruction
    legal       = 1'b0;
    rs1_used    = 1'b0;
    rs2_used    = 1'b0;
    alu_op      = pipe_pkg::ADD;
    alu_src_imm = 1'b0;
    imm         = {{20{instr[31]}}, instr[isa_pkg::IMM_I_LSB +: 12]};
    case (opcode)
      isa_pkg::OP:
      begin
        rs1_used = 1'b1;
        rs2_used = 1'b1;
        // Alternate funct7 only exists for SUB and SRA
        legal = (funct7 == isa_pkg::F7_BASE) ||
                ((funct7 == isa_pkg::F7_ALT) &&
                 ((funct3 == isa_pkg::F3_ADD_SUB) || (funct3 == isa_pkg::F3_SRL_SRA)));
        alu_op = ((funct3 == isa_pkg::F3_ADD_SUB) && alt) ? pipe_pkg::SUB : f3_op;
      end
      isa_pkg::OP_IMM:
      begin
        rs1_used    = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = f3_op;
        // Shift-immediates keep funct7 in the upper immediate bits
        if (funct3 == isa_pkg::F3_SLL)
          legal = (funct7 == isa_pkg::F7_BASE);
        else if (funct3 == isa_pkg::F3_SRL_SRA)
          legal = (funct7 == isa_pkg::F7_BASE) || (funct7 == isa_pkg::F7_ALT);
        else
          legal = 1'b1;
      end
      isa_pkg::LUI:
      begin
        legal       = 1'b1;
        alu_src_imm = 1'b1;
        alu_op      = pipe_pkg::PASS_B;
        imm         = {instr[31:isa_pkg::IMM_U_LSB], 12'b0};
      end
      default:
      begin
        legal = 1'b0;
      end
    endcase
  end

  // Every legal instruction here writes rd
  assign illegal   = !legal;
  assign reg_write = legal;

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none
`timescale 1ns/1ps

module reg_file (
  input  wire                clk,
  input  wire                rst_n,
  input  isa_pkg::reg_idx_t  raddr1,
  input  isa_pkg::reg_idx_t  raddr2,
  input  wire                we,
  input  isa_pkg::reg_idx_t  waddr,
  input  isa_pkg::word_t     wdata,
  output isa_pkg::word_t     rdata1,
  output isa_pkg::word_t     rdata2
);

  // x0 has no storage
  isa_pkg::word_t regs [1:31];

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 1; i < 32; i++)
        regs[i] <= '0;
    end
    else if (we && (waddr != '0))
    begin
      regs[waddr] <= wdata;
    end
  end

  // Read is combinational; a same-cycle write shows up next cycle
  assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
  assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: hdl/decode_exec_reg.sv
`default_nettype none
`timescale 1ns/1ps

module decode_exec_reg (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                load,
  input  wire                valid_in,
  input  isa_pkg::word_t     op_a_in,
  input  isa_pkg::word_t     op_b_in,
  input  isa_pkg::word_t     imm_in,
  input  isa_pkg::reg_idx_t  rd_in,
  input  pipe_pkg::alu_op_e  alu_op_in,
  input  wire                alu_src_imm_in,
  input  wire                reg_write_in,
  input  wire                illegal_in,
  output logic               valid,
  output isa_pkg::word_t     op_a,
  output isa_pkg::word_t     op_b,
  output isa_pkg::word_t     imm,
  output isa_pkg::reg_idx_t  rd,
  output pipe_pkg::alu_op_e  alu_op,
  output logic               alu_src_imm,
  output logic               reg_write,
  output logic               illegal
);

  // Slot occupancy
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      valid <= 1'b0;
    else if (load)
      valid <= valid_in;
  end

  // Payload, meaningful only while valid
  always_ff @(posedge clk)
  begin
    if (load)
    begin
      op_a        <= op_a_in;
      op_b        <= op_b_in;
      imm         <= imm_in;
      rd          <= rd_in;
      alu_op      <= alu_op_in;
      alu_src_imm <= alu_src_imm_in;
      reg_write   <= reg_write_in;
      illegal     <= illegal_in;
    end
  end

endmodule

`default_nettype wire

// File: hdl/alu_exec.sv
`default_nettype none
`timescale 1ns/1ps

module alu_exec (
  input  isa_pkg::word_t     op_a,
  input  isa_pkg::word_t     op_b,
  input  isa_pkg::word_t     imm,
  input  wire                alu_src_imm,
  input  pipe_pkg::alu_op_e  alu_op,
  output isa_pkg::word_t     result
);

  isa_pkg::word_t operand_b;
  logic [4:0]     shamt;

  // Immediate forms replace the second register operand
  assign operand_b = alu_src_imm ? imm : op_b;
  assign shamt     = operand_b[4:0];

  always_comb
  begin
    case (alu_op)
      pipe_pkg::ADD:    result = op_a + operand_b;
      pipe_pkg::SUB:    result = op_a - operand_b;
      pipe_pkg::SLL:    result = op_a << shamt;
      pipe_pkg::SLT:    result = {31'b0, $signed(op_a) < $signed(operand_b)};
      pipe_pkg::SLTU:   result = {31'b0, op_a < operand_b};
      pipe_pkg::XOR:    result = op_a ^ operand_b;
      pipe_pkg::SRL:    result = op_a >> shamt;
      // Arithmetic shift keeps the sign
      pipe_pkg::SRA:    result = $unsigned($signed(op_a) >>> shamt);
      pipe_pkg::OR:     result = op_a | operand_b;
      pipe_pkg::AND:    result = op_a & operand_b;
      pipe_pkg::PASS_B: result = operand_b;
      default:          result = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/pipeline_ctrl.sv
`default_nettype none
`timescale 1ns/1ps

module pipeline_ctrl #(
  parameter int OUT_CREDITS = 2
) (
  input  wire                 clk,
  input  wire                 rst_n,
  input  wire                 out_credit,
  input  wire                 q_empty,
  input  isa_pkg::reg_idx_t   rs1,
  input  isa_pkg::reg_idx_t   rs2,
  input  wire                 rs1_used,
  input  wire                 rs2_used,
  input  wire                 ex_valid,
  input  isa_pkg::reg_idx_t   ex_rd,
  input  wire                 ex_reg_write,
  output logic                q_pop,
  output logic                de_load,
  output logic                de_valid_in,
  output logic                rf_we,
  output logic                out_load,
  output pipe_pkg::fwd_sel_e  fwd_a,
  output pipe_pkg::fwd_sel_e  fwd_b,
  output logic                in_credit
);

  localparam int CNT_W = $clog2(OUT_CREDITS + 1);

  logic [CNT_W-1:0] credit_cnt;
  logic             fire;
  logic             ex_writes;

  // Execute fires only with a credit in hand
  assign fire     = ex_valid && (credit_cnt != '0);
  assign out_load = fire;
  assign rf_we    = fire && ex_reg_write && (ex_rd != '0);

  // Queue head moves in when the slot is free or draining this edge
  assign de_load     = !ex_valid || fire;
  assign de_valid_in = !q_empty;
  assign q_pop       = de_load && !q_empty;

  // Bypass from the instruction sitting in execute
  assign ex_writes = ex_valid && ex_reg_write && (ex_rd != '0);
  assign fwd_a = (ex_writes && rs1_used && (rs1 == ex_rd)) ? pipe_pkg::EXEC : pipe_pkg::REGFILE;
  assign fwd_b = (ex_writes && rs2_used && (rs2 == ex_rd)) ? pipe_pkg::EXEC : pipe_pkg::REGFILE;

  // Output credit count where a gain and a spend may coincide
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      credit_cnt <= CNT_W'(OUT_CREDITS);
    else
      credit_cnt <= credit_cnt + CNT_W'(out_credit) - CNT_W'(fire);
  end

  // Credit for each popped entry goes back to the source a cycle later
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      in_credit <= 1'b0;
    else
      in_credit <= q_pop;
  end

  // Sink returns no more than it was given
  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CNT_W'(OUT_CREDITS));

  // A stalled instruction stays in execute until a credit frees it
  stall_holds: assert property (@(posedge clk) disable iff (!rst_n)
    (ex_valid && !fire) |=> (ex_valid && $stable(ex_rd)));

endmodule

`default_nettype wire

// File: hdl/decode_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

module decode_exec_top #(
  parameter int IN_DEPTH    = 4,
  parameter int OUT_CREDITS = 2
) (
  input  wire                clk,
  input  wire                rst_n,
  input  wire                in_valid,
  input  isa_pkg::word_t     in_instr,
  input  wire                out_credit,
  output logic               in_credit,
  output logic               out_valid,
  output isa_pkg::reg_idx_t  out_rd,
  output isa_pkg::word_t     out_data,
  output logic               out_illegal
);

  // Queue and decode
  isa_pkg::word_t     q_head;
  logic               q_empty;
  logic               q_pop;
  isa_pkg::reg_idx_t  dec_rs1;
  isa_pkg::reg_idx_t  dec_rs2;
  logic               dec_rs1_used;
  logic               dec_rs2_used;
  isa_pkg::reg_idx_t  dec_rd;
  isa_pkg::word_t     dec_imm;
  pipe_pkg::alu_op_e  dec_alu_op;
  logic               dec_alu_src_imm;
  logic               dec_reg_write;
  logic               dec_illegal;
  // Operand read and bypass
  isa_pkg::word_t     rf_rdata1;
  isa_pkg::word_t     rf_rdata2;
  pipe_pkg::fwd_sel_e fwd_a;
  pipe_pkg::fwd_sel_e fwd_b;
  isa_pkg::word_t     op_a;
  isa_pkg::word_t     op_b;
  // Execute stage
  logic               de_load;
  logic               de_valid_in;
  logic               ex_valid;
  isa_pkg::word_t     ex_op_a;
  isa_pkg::word_t     ex_op_b;
  isa_pkg::word_t     ex_imm;
  isa_pkg::reg_idx_t  ex_rd;
  pipe_pkg::alu_op_e  ex_alu_op;
  logic               ex_alu_src_imm;
  logic               ex_reg_write;
  logic               ex_illegal;
  isa_pkg::word_t     alu_result;
  logic               rf_we;
  logic               out_load;

  instr_queue #(
    .IN_DEPTH (IN_DEPTH)
  ) u_queue (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (in_valid),
    .push_data (in_instr),
    .pop       (q_pop),
    .head      (q_head),
    .empty     (q_empty)
  );

  instr_decoder u_decoder (
    .instr       (q_head),
    .rs1         (dec_rs1),
    .rs2         (dec_rs2),
    .rs1_used    (dec_rs1_used),
    .rs2_used    (dec_rs2_used),
    .rd          (dec_rd),
    .imm         (dec_imm),
    .alu_op      (dec_alu_op),
    .alu_src_imm (dec_alu_src_imm),
    .reg_write   (dec_reg_write),
    .illegal     (dec_illegal)
  );

  // Write port is fed straight from execute
  reg_file u_regs (
    .clk    (clk),
    .rst_n  (rst_n),
    .raddr1 (dec_rs1),
    .raddr2 (dec_rs2),
    .we     (rf_we),
    .waddr  (ex_rd),
    .wdata  (alu_result),
    .rdata1 (rf_rdata1),
    .rdata2 (rf_rdata2)
  );

  // Result of the older instruction replaces a stale register read
  assign op_a = (fwd_a == pipe_pkg::EXEC) ? alu_result : rf_rdata1;
  assign op_b = (fwd_b == pipe_pkg::EXEC) ? alu_result : rf_rdata2;

  decode_exec_reg u_de_reg (
    .clk            (clk),
    .rst_n          (rst_n),
    .load           (de_load),
    .valid_in       (de_valid_in),
    .op_a_in        (op_a),
    .op_b_in        (op_b),
    .imm_in         (dec_imm),
    .rd_in          (dec_rd),
    .alu_op_in      (dec_alu_op),
    .alu_src_imm_in (dec_alu_src_imm),
    .reg_write_in   (dec_reg_write),
    .illegal_in     (dec_illegal),
    .valid          (ex_valid),
    .op_a           (ex_op_a),
    .op_b           (ex_op_b),
    .imm            (ex_imm),
    .rd             (ex_rd),
    .alu_op         (ex_alu_op),
    .alu_src_imm    (ex_alu_src_imm),
    .reg_write      (ex_reg_write),
    .illegal        (ex_illegal)
  );

  alu_exec u_alu (
    .op_a        (ex_op_a),
    .op_b        (ex_op_b),
    .imm         (ex_imm),
    .alu_src_imm (ex_alu_src_imm),
    .alu_op      (ex_alu_op),
    .result      (alu_result)
  );

  pipeline_ctrl #(
    .OUT_CREDITS (OUT_CREDITS)
  ) u_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_credit   (out_credit),
    .q_empty      (q_empty),
    .rs1          (dec_rs1),
    .rs2          (dec_rs2),
    .rs1_used     (dec_rs1_used),
    .rs2_used     (dec_rs2_used),
    .ex_valid     (ex_valid),
    .ex_rd        (ex_rd),
    .ex_reg_write (ex_reg_write),
    .q_pop        (q_pop),
    .de_load      (de_load),
    .de_valid_in  (de_valid_in),
    .rf_we        (rf_we),
    .out_load     (out_load),
    .fwd_a        (fwd_a),
    .fwd_b        (fwd_b),
    .in_credit    (in_credit)
  );

  // One beat per execute fire
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      out_valid <= 1'b0;
    else
      out_valid <= out_load;
  end

  // Illegal items carry zero data
  always_ff @(posedge clk)
  begin
    if (out_load)
    begin
      out_rd      <= ex_rd;
      out_data    <= ex_illegal ? '0 : alu_result;
      out_illegal <= ex_illegal;
    end
  end

endmodule

`default_nettype wire

// File: verification/tb_decode_exec.sv
`default_nettype none
`timescale 1ns/1ps

module tb_decode_exec;

  localparam int IN_DEPTH    = 4;
  localparam int OUT_CREDITS = 2;
  localparam int DRAIN_LIMIT = 4000;

  logic               clk = 1'b0;
  logic               rst_n;
  logic               in_valid;
  isa_pkg::word_t     in_instr;
  logic               out_credit;
  logic               in_credit;
  logic               out_valid;
  isa_pkg::reg_idx_t  out_rd;
  isa_pkg::word_t     out_data;
  logic               out_illegal;

  // Architectural state as the reference sees it
  isa_pkg::word_t ref_regs [32];
  // Instructions waiting for a source credit
  isa_pkg::word_t tx_q [$];
  // Expected {illegal, rd, data} in program order
  logic [37:0]    exp_q [$];
  logic [31:0]    rng_state        = 32'd60;
  int             src_credits      = IN_DEPTH;
  int             owed_credits     = 0;
  int             credits_returned = 0;
  int             beats            = 0;
  logic           hold_mode        = 1'b0;
  int             errors           = 0;
  int             checks           = 0;
  int             tests            = 0;
  int             failed_tests     = 0;

  decode_exec_top #(
    .IN_DEPTH    (IN_DEPTH),
    .OUT_CREDITS (OUT_CREDITS)
  ) UUT (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .in_instr    (in_instr),
    .out_credit  (out_credit),
    .in_credit   (in_credit),
    .out_valid   (out_valid),
    .out_rd      (out_rd),
    .out_data    (out_data),
    .out_illegal (out_illegal)
  );

  initial
  begin
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // RV32I semantics for the supported subset
  // Illegal items carry zero data
  function automatic isa_pkg::word_t expected_result(input isa_pkg::word_t instr,
                                                     output logic illegal);
    logic [6:0]     opcode;
    logic [2:0]     f3;
    logic [6:0]     f7;
    isa_pkg::word_t a;
    isa_pkg::word_t b;
    isa_pkg::word_t imm_i;
    logic [4:0]     sh;
    isa_pkg::word_t res;
    opcode  = instr[6:0];
    f3      = instr[14:12];
    f7      = instr[31:25];
    a       = ref_regs[instr[19:15]];
    b       = ref_regs[instr[24:20]];
    imm_i   = {{20{instr[31]}}, instr[31:20]};
    illegal = 1'b0;
    res     = '0;
    if (opcode == isa_pkg::OP)
    begin
      sh = b[4:0];
      if (f7 == 7'h00)
      begin
        case (f3)
          3'd0: res = a + b;
          3'd1: res = a << sh;
          3'd2: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'd3: res = (a < b) ? 32'd1 : 32'd0;
          3'd4: res = a ^ b;
          3'd5: res = a >> sh;
          3'd6: res = a | b;
          default: res = a & b;
        endcase
      end
      else if ((f7 == 7'h20) && (f3 == 3'd0))
        res = a - b;
      else if ((f7 == 7'h20) && (f3 == 3'd5))
        res = $signed(a) >>> sh;
      else
        illegal = 1'b1;
    end
    else if (opcode == isa_pkg::OP_IMM)
    begin
      // Shift amount sits in the rs2 field
      sh = instr[24:20];
      case (f3)
        3'd0: res = a + imm_i;
        3'd1:
        begin
          if (f7 == 7'h00)
            res = a << sh;
          else
            illegal = 1'b1;
        end
        3'd2: res = ($signed(a) < $signed(imm_i)) ? 32'd1 : 32'd0;
        3'd3: res = (a < imm_i) ? 32'd1 : 32'd0;
        3'd4: res = a ^ imm_i;
        3'd5:
        begin
          if (f7 == 7'h00)
            res = a >> sh;
          else if (f7 == 7'h20)
            res = $signed(a) >>> sh;
          else
            illegal = 1'b1;
        end
        3'd6: res = a | imm_i;
        default: res = a & imm_i;
      endcase
    end
    else if (opcode == isa_pkg::LUI)
      res = {instr[31:12], 12'h000};
    else
      illegal = 1'b1;
    if (illegal)
      res = '0;
    return res;
  endfunction

  function automatic isa_pkg::word_t r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                                 input logic [4:0] rs1, input logic [2:0] f3,
                                                 input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OP};
  endfunction

  function automatic isa_pkg::word_t i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                                 input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, isa_pkg::OP_IMM};
  endfunction

  function automatic isa_pkg::word_t lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, isa_pkg::LUI};
  endfunction

  // {funct7, funct3} of the ten register-register operations
  function automatic logic [9:0] alu_fields(input int idx);
    case (idx)
      0: return {isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB};
      1: return {isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB};
      2: return {isa_pkg::F7_BASE, isa_pkg::F3_SLL};
      3: return {isa_pkg::F7_BASE, isa_pkg::F3_SLT};
      4: return {isa_pkg::F7_BASE, isa_pkg::F3_SLTU};
      5: return {isa_pkg::F7_BASE, isa_pkg::F3_XOR};
      6: return {isa_pkg::F7_BASE, isa_pkg::F3_SRL_SRA};
      7: return {isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA};
      8: return {isa_pkg::F7_BASE, isa_pkg::F3_OR};
      default: return {isa_pkg::F7_BASE, isa_pkg::F3_AND};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
      errors++;
    end
  endtask

  // Reference runs at queue time in the order the DUT executes
  task automatic send_instr(input isa_pkg::word_t instr);
    isa_pkg::word_t    data;
    logic              ill;
    isa_pkg::reg_idx_t rd;
    rd   = instr[11:7];
    data = expected_result(instr, ill);
    if (!ill && (rd != '0))
      ref_regs[rd] = data;
    exp_q.push_back({ill, rd, data});
    tx_q.push_back(instr);
  endtask

  // LUI then ADDI with the upper part rounded for the sign of the low 12 bits
  task automatic load_reg(input logic [4:0] rd, input isa_pkg::word_t value);
    logic [19:0] upper;
    upper = value[31:12] + {19'd0, value[11]};
    send_instr(lui_word(upper, rd));
    send_instr(i_type_word(value[11:0], rd, isa_pkg::F3_ADD_SUB, rd));
  endtask

  task automatic drain_all();
    int waited;
    waited = 0;
    while (((tx_q.size() != 0) || (exp_q.size() != 0)) && (waited < DRAIN_LIMIT))
    begin
      @(posedge clk);
      waited++;
    end
    if ((tx_q.size() != 0) || (exp_q.size() != 0))
    begin
      $display("Timeout: %0d instructions unsent and %0d results missing",
               tx_q.size(), exp_q.size());
      errors++;
      tx_q.delete();
      exp_q.delete();
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before)
      $display("Test %0d %s: ok", tests, name);
    else
    begin
      failed_tests++;
      $display("Test %0d %s: failed with %0d errors", tests, name, errors - err_before);
    end
  endtask

  // Source sends one beat per credit held
  always @(negedge clk)
  begin
    if (in_credit === 1'b1)
      src_credits++;
    if (src_credits > IN_DEPTH)
    begin
      $display("Input credit returned beyond the queue depth");
      errors++;
    end
    if ((tx_q.size() != 0) && (src_credits > 0))
    begin
      in_valid = 1'b1;
      in_instr = tx_q.pop_front();
      src_credits--;
    end
    else
    begin
      in_valid = 1'b0;
      in_instr = '0;
    end
  end

  // Sink compares each beat and returns credits at a random rate
  always @(negedge clk)
  begin : sink_side
    logic [31:0] r;
    logic [37:0] exp;
    if (out_valid === 1'b1)
    begin
      beats++;
      if (beats > OUT_CREDITS + credits_returned)
      begin
        $display("Output beat %0d arrived without an output credit", beats);
        errors++;
      end
      owed_credits++;
      if (exp_q.size() == 0)
      begin
        $display("Output beat arrived with no instruction outstanding");
        errors++;
      end
      else
      begin
        exp = exp_q.pop_front();
        check_value("out_rd", 32'(out_rd), 32'(exp[36:32]));
        check_value("out_data", out_data, exp[31:0]);
        check_value("out_illegal", 32'(out_illegal), 32'(exp[37]));
      end
    end
    r = next_rand();
    // Withholding mode returns about one credit in eight cycles
    if ((owed_credits > 0) && (hold_mode ? (r[2:0] == 3'd0) : r[0]))
    begin
      out_credit = 1'b1;
      owed_credits--;
      credits_returned++;
    end
    else
      out_credit = 1'b0;
  end

  initial
  begin
    int                err_before;
    logic [31:0]       r;
    logic [9:0]        fields;
    logic [11:0]       imm;
    logic [2:0]        f3;
    isa_pkg::reg_idx_t prev;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t tgt;
    rst_n      = 1'b0;
    in_valid   = 1'b0;
    in_instr   = '0;
    out_credit = 1'b0;
    for (int i = 0; i < 32; i++)
      ref_regs[i] = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset
    err_before = errors;
    repeat (20)
    begin
      @(negedge clk);
      check_value("out_valid", 32'(out_valid), 32'd0);
      check_value("in_credit", 32'(in_credit), 32'd0);
    end
    report_test("idle after reset", err_before);
    @(posedge clk);

    // All ten register-register operations on random state
    err_before = errors;
    for (int i = 1; i < 32; i++)
      load_reg(5'(i), next_rand());
    for (int k = 0; k < 40; k++)
    begin
      r      = next_rand();
      fields = alu_fields(k % 10);
      send_instr(r_type_word(fields[9:3], r[9:5], r[4:0], fields[2:0], r[14:10]));
    end
    drain_all();
    report_test("register operations", err_before);

    // Immediate forms where alternate rounds of eight force a negative immediate
    err_before = errors;
    for (int k = 0; k < 32; k++)
    begin
      r   = next_rand();
      f3  = 3'(k % 8);
      imm = r[31:20];
      if ((k / 8) % 2 == 0)
        imm[11] = 1'b1;
      if (f3 == isa_pkg::F3_SLL)
        imm = {7'h00, r[24:20]};
      else if (f3 == isa_pkg::F3_SRL_SRA)
        imm = {(r[15] ? 7'h20 : 7'h00), r[24:20]};
      send_instr(i_type_word(imm, r[4:0], f3, r[9:5]));
    end
    for (int k = 0; k < 6; k++)
    begin
      r = next_rand();
      send_instr(lui_word(r[31:12], r[4:0]));
    end
    drain_all();
    report_test("immediate operations", err_before);

    // Each instruction reads the previous rd and every sixth one writes x0
    err_before = errors;
    prev = 5'(1 + next_rand() % 31);
    for (int k = 0; k < 24; k++)
    begin
      r  = next_rand();
      rd = (k % 6 == 3) ? 5'd0 : 5'(1 + r % 31);
      if (k % 2 == 0)
      begin
        fields = alu_fields(int'(r[19:16]) % 10);
        send_instr(r_type_word(fields[9:3], (k % 4 == 0) ? prev : r[24:20], prev,
                               fields[2:0], rd));
      end
      else
        send_instr(i_type_word(r[31:20], prev, isa_pkg::F3_ADD_SUB, rd));
      prev = rd;
    end
    drain_all();
    report_test("forwarding chains", err_before);

    // Sink starves the core of credits
    err_before = errors;
    hold_mode = 1'b1;
    for (int k = 0; k < 16; k++)
    begin
      r      = next_rand();
      fields = alu_fields(k % 10);
      send_instr(r_type_word(fields[9:3], r[9:5], r[4:0], fields[2:0], r[14:10]));
    end
    drain_all();
    hold_mode = 1'b0;
    report_test("output back-pressure", err_before);

    // Illegal encodings each followed by a read of rd into x0
    err_before = errors;
    for (int k = 0; k < 6; k++)
    begin
      r   = next_rand();
      tgt = 5'(1 + r % 31);
      case (k)
        0: send_instr({r[31:12], tgt, 7'b0000011});
        1: send_instr(r_type_word(7'h01, r[9:5], r[14:10], isa_pkg::F3_ADD_SUB, tgt));
        2: send_instr(r_type_word(isa_pkg::F7_ALT, r[9:5], r[14:10], isa_pkg::F3_SLL, tgt));
        3: send_instr(i_type_word({7'h20, 5'd3}, r[14:10], isa_pkg::F3_SLL, tgt));
        4: send_instr(i_type_word({7'h10, 5'd3}, r[14:10], isa_pkg::F3_SRL_SRA, tgt));
        default: send_instr({r[31:12], tgt, 7'b1101111});
      endcase
      send_instr(i_type_word(12'h000, tgt, isa_pkg::F3_ADD_SUB, 5'd0));
    end
    drain_all();
    report_test("illegal encodings", err_before);

    $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
             tests, failed_tests, checks, errors);
    if (errors == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: compile.f
hdl/isa_pkg.sv
hdl/pipe_pkg.sv
hdl/instr_queue.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/decode_exec_reg.sv
hdl/alu_exec.sv
hdl/pipeline_ctrl.sv
hdl/decode_exec_top.sv
verification/tb_decode_exec.sv

// File: Bender.yml
package:
  name: decode_exec

sources:
  - files:
      - hdl/isa_pkg.sv
      - hdl/pipe_pkg.sv
      - hdl/instr_queue.sv
      - hdl/instr_decoder.sv
      - hdl/reg_file.sv
      - hdl/decode_exec_reg.sv
      - hdl/alu_exec.sv
      - hdl/pipeline_ctrl.sv
      - hdl/decode_exec_top.sv
  - target: test
    files:
      - verification/tb_decode_exec.sv
